//--- mcu_top.f
+incdir+rtl
rtl/mcu_pkg.sv
rtl/mcu_fetch.sv
rtl/mcu_decode_exec.sv
rtl/mcu_lsu.sv
rtl/mcu_irq_ctrl.sv
rtl/mcu_top.sv
verif/mcu_tb.sv

//--- rtl/mcu_cfg.svh
// MCU subsystem configuration
`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

// ----------------------------------------------------------------------
// Datapath
// ----------------------------------------------------------------------

// Data and address width of the core and both OBI buses
`define MCU_XLEN 32

// Register file depth with register 0 hardwired to zero
`define MCU_NREG 16

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------

// First fetch address after reset
`define MCU_BOOT_ADDR 32'h0000_0000

// Vector for line n sits at base + 4*n
`define MCU_IRQ_VEC_BASE 32'h0000_0100

// Lines per interrupt source
`define MCU_NIRQ 8

`endif

//--- rtl/mcu_decode_exec.sv
// Decode and execute stage
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module mcu_decode_exec (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  input  wire logic                          pkt_valid_i,
  input  wire mcu_pkg::fetch_pkt_t           pkt_i,
  output logic                               pkt_ready_o,
  output logic                               mem_valid_o,
  output mcu_pkg::mem_req_t                  mem_o,
  input  wire logic                          mem_ready_i,
  input  wire logic                          wb_valid_i,
  input  wire logic [mcu_pkg::REG_AW-1:0]    wb_rd_i,
  input  wire logic [`MCU_XLEN-1:0]          wb_data_i,
  input  wire mcu_pkg::irq_t                 irq_i,
  output logic                               irq_take_o,
  output logic [`MCU_XLEN-1:0]               redirect_addr_o
);

  localparam int unsigned IDW = mcu_pkg::IRQ_IDW;

  mcu_pkg::instr_u      instr;
  mcu_pkg::opcode_e     op;
  logic [`MCU_XLEN-1:0] regs [`MCU_NREG];
  logic [`MCU_XLEN-1:0] rs1_val;
  logic [`MCU_XLEN-1:0] rs2_val;
  logic [`MCU_XLEN-1:0] rd_val;
  logic [`MCU_XLEN-1:0] imm_sext;
  logic [`MCU_XLEN-1:0] alu_res;
  logic                 is_alu;
  logic                 is_mem;
  logic                 accept;
  logic                 alu_we;
  logic                 take_q;

  assign instr = pkt_i.instr;
  assign op    = instr.r_form.opcode;

  // ----------------------------------------------------------------------
  // Operand read
  // ----------------------------------------------------------------------

  assign rs1_val = (instr.r_form.rs1 == '0) ? '0 : regs[instr.r_form.rs1];
  assign rs2_val = (instr.r_form.rs2 == '0) ? '0 : regs[instr.r_form.rs2];
  // SW takes its store data from the rd field
  assign rd_val  = (instr.i_form.rd == '0) ? '0 : regs[instr.i_form.rd];

  assign imm_sext = {{(`MCU_XLEN-20){instr.i_form.imm[19]}}, instr.i_form.imm};

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------

  always_comb begin
    alu_res = '0;
    is_alu  = 1'b1;
    is_mem  = 1'b0;
    case (op)
      mcu_pkg::OP_ADD:  alu_res = rs1_val + rs2_val;
      mcu_pkg::OP_SUB:  alu_res = rs1_val - rs2_val;
      mcu_pkg::OP_AND:  alu_res = rs1_val & rs2_val;
      mcu_pkg::OP_OR:   alu_res = rs1_val | rs2_val;
      mcu_pkg::OP_XOR:  alu_res = rs1_val ^ rs2_val;
      mcu_pkg::OP_ADDI: alu_res = rs1_val + imm_sext;
      mcu_pkg::OP_LUI:  alu_res = {instr.i_form.imm[15:0], 16'h0000};
      mcu_pkg::OP_LW, mcu_pkg::OP_SW: begin
        is_alu = 1'b0;
        is_mem = 1'b1;
      end
      // NOP and unused encodings retire without effect
      default: is_alu = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Issue and interrupt take
  // ----------------------------------------------------------------------

  // Nothing issues while the LSU is busy, which covers load-use
  assign irq_take_o  = irq_i.valid && mem_ready_i && !take_q;
  assign pkt_ready_o = mem_ready_i && !irq_take_o;
  assign accept      = pkt_valid_i && pkt_ready_o;
  assign mem_valid_o = pkt_valid_i && is_mem && !irq_take_o;
  assign alu_we      = accept && is_alu && (instr.i_form.rd != '0);

  always_comb begin
    mem_o.we    = (op == mcu_pkg::OP_SW);
    mem_o.addr  = rs1_val + imm_sext;
    mem_o.wdata = rd_val;
    mem_o.rd    = instr.i_form.rd;
  end

  assign redirect_addr_o = `MCU_IRQ_VEC_BASE + {{(`MCU_XLEN-IDW-2){1'b0}}, irq_i.id, 2'b00};

  // Merged vector lags one cycle so the cycle after a take is skipped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      take_q <= 1'b0;
    end else begin
      take_q <= irq_take_o;
    end
  end

  // Load write-back and ALU issue never coincide as the LSU is busy during a load
  always_ff @(posedge clk_i) begin
    if (wb_valid_i && (wb_rd_i != '0)) begin
      regs[wb_rd_i] <= wb_data_i;
    end else if (alu_we) begin
      regs[instr.i_form.rd] <= alu_res;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mcu_fetch.sv
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module mcu_fetch (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  output mcu_pkg::obi_req_t         instr_obi_o,
  input  wire mcu_pkg::obi_rsp_t    instr_obi_i,
  output logic                      pkt_valid_o,
  output mcu_pkg::fetch_pkt_t       pkt_o,
  input  wire logic                 pkt_ready_i,
  input  wire logic                 redirect_i,
  input  wire logic [`MCU_XLEN-1:0] redirect_addr_i
);

  logic                 run_q;
  logic [`MCU_XLEN-1:0] pc_q;
  logic [`MCU_XLEN-1:0] addr_q;
  logic                 hold_q;
  logic                 pend_q;
  logic                 drop_q;
  logic                 buf_valid_q;
  mcu_pkg::fetch_pkt_t  buf_q;
  logic                 can_start;
  logic                 req;
  logic                 fire;

  // Buffer is free or drains this cycle
  assign can_start = !buf_valid_q || pkt_ready_i;
  // A held request stays up until granted even across a redirect
  assign req  = run_q && !pend_q && (hold_q || (can_start && !redirect_i));
  assign fire = req && instr_obi_i.gnt;

  always_comb begin
    instr_obi_o.req   = req;
    instr_obi_o.addr  = hold_q ? addr_q : pc_q;
    instr_obi_o.we    = 1'b0;
    instr_obi_o.be    = '1;
    instr_obi_o.wdata = '0;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q       <= 1'b0;
      pc_q        <= `MCU_BOOT_ADDR;
      hold_q      <= 1'b0;
      pend_q      <= 1'b0;
      drop_q      <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      run_q  <= 1'b1;
      hold_q <= req && !instr_obi_i.gnt;
      if (fire) begin
        pend_q <= 1'b1;
      end else if (instr_obi_i.rvalid) begin
        pend_q <= 1'b0;
      end
      if (redirect_i) begin
        // Anything held, granted or in flight now belongs to the old stream
        pc_q        <= redirect_addr_i;
        drop_q      <= req || (pend_q && !instr_obi_i.rvalid);
        buf_valid_q <= 1'b0;
      end else begin
        if (fire && !drop_q) begin
          pc_q <= pc_q + `MCU_XLEN'(4);
        end
        if (instr_obi_i.rvalid) begin
          drop_q <= 1'b0;
        end
        if (instr_obi_i.rvalid && !drop_q) begin
          buf_valid_q <= 1'b1;
        end else if (pkt_ready_i) begin
          buf_valid_q <= 1'b0;
        end
      end
    end
  end

  // Request address and fetched word
  always_ff @(posedge clk_i) begin
    if (req && !hold_q) begin
      addr_q <= pc_q;
    end
    if (instr_obi_i.rvalid && !drop_q) begin
      buf_q.instr <= instr_obi_i.rdata;
      buf_q.addr  <= addr_q;
    end
  end

  assign pkt_valid_o = buf_valid_q;
  assign pkt_o       = buf_q;

endmodule

`default_nettype wire

//--- rtl/mcu_irq_ctrl.sv
// Interrupt merge and select
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module mcu_irq_ctrl (
  input  wire logic                        clk_i,
  input  wire logic                        rst_n_i,
  input  wire logic [`MCU_NIRQ-1:0]        irq_ext_i,
  input  wire logic [`MCU_NIRQ-1:0]        irq_vp_i,
  input  wire logic                        irq_take_i,
  output mcu_pkg::irq_t                    irq_o,
  output logic                             irq_ack_o,
  output logic [mcu_pkg::IRQ_IDW-1:0]      irq_id_o
);

  localparam int unsigned IDW = mcu_pkg::IRQ_IDW;

  logic [`MCU_NIRQ-1:0] merged_q;
  logic [IDW-1:0]       sel;
  logic                 ack_q;
  logic [IDW-1:0]       id_q;

  // Lowest set line wins as the scan runs from the top down
  always_comb begin
    sel = '0;
    for (int i = `MCU_NIRQ - 1; i >= 0; i--) begin
      if (merged_q[i]) begin
        sel = IDW'(i);
      end
    end
  end

  assign irq_o.valid = |merged_q;
  assign irq_o.id    = sel;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      merged_q <= '0;
      ack_q    <= 1'b0;
      id_q     <= '0;
    end else begin
      merged_q <= irq_ext_i | irq_vp_i;
      ack_q    <= irq_take_i;
      if (irq_take_i) begin
        id_q <= sel;
      end
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

endmodule

`default_nettype wire

//--- rtl/mcu_lsu.sv
// Load/store unit
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module mcu_lsu (
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire logic                       mem_valid_i,
  input  wire mcu_pkg::mem_req_t          mem_i,
  output logic                            mem_ready_o,
  output mcu_pkg::obi_req_t               data_obi_o,
  input  wire mcu_pkg::obi_rsp_t          data_obi_i,
  output logic                            wb_valid_o,
  output logic [mcu_pkg::REG_AW-1:0]      wb_rd_o,
  output logic [`MCU_XLEN-1:0]            wb_data_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT
  } state_e;

  state_e            state_q;
  mcu_pkg::mem_req_t req_q;

  assign mem_ready_o = (state_q == S_IDLE);

  // ----------------------------------------------------------------------
  // Data bus
  // ----------------------------------------------------------------------

  // Address and data come from the latched request and stay put while gnt is low
  always_comb begin
    data_obi_o.req   = (state_q == S_REQ);
    data_obi_o.addr  = req_q.addr;
    data_obi_o.we    = req_q.we;
    data_obi_o.be    = '1;
    data_obi_o.wdata = req_q.wdata;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (mem_valid_i) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          if (data_obi_i.gnt) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (data_obi_i.rvalid) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_valid_i && mem_ready_o) begin
      req_q <= mem_i;
    end
  end

  // ----------------------------------------------------------------------
  // Write-back
  // ----------------------------------------------------------------------

  // Stores finish on rvalid with nothing to return
  assign wb_valid_o = (state_q == S_WAIT) && data_obi_i.rvalid && !req_q.we;
  assign wb_rd_o    = req_q.rd;
  assign wb_data_o  = data_obi_i.rdata;

endmodule

`default_nettype wire

//--- rtl/mcu_pkg.sv
// MCU shared types
`default_nettype none

`include "mcu_cfg.svh"

package mcu_pkg;

  localparam int unsigned REG_AW  = $clog2(`MCU_NREG);
  localparam int unsigned IRQ_IDW = $clog2(`MCU_NIRQ);

  // ----------------------------------------------------------------------
  // Instruction encoding
  // ----------------------------------------------------------------------

  // Opcode lives in bits 31:28
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_ADDI = 4'h6,
    OP_LUI  = 4'h7,
    OP_LW   = 4'h8,
    OP_SW   = 4'h9
  } opcode_e;

  typedef struct packed {
    opcode_e           opcode;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [15:0]       unused;
  } r_form_t;

  // Immediate is sign-extended except for LUI
  typedef struct packed {
    opcode_e           opcode;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [19:0]       imm;
  } i_form_t;

  typedef union packed {
    r_form_t r_form;
    i_form_t i_form;
  } instr_u;

  // ----------------------------------------------------------------------
  // Stage to stage
  // ----------------------------------------------------------------------

  typedef struct packed {
    instr_u               instr;
    logic [`MCU_XLEN-1:0] addr;
  } fetch_pkt_t;

  typedef struct packed {
    logic                 we;
    logic [`MCU_XLEN-1:0] addr;
    logic [`MCU_XLEN-1:0] wdata;
    logic [REG_AW-1:0]    rd;
  } mem_req_t;

  // ----------------------------------------------------------------------
  // OBI and interrupts
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic                   req;
    logic [`MCU_XLEN-1:0]   addr;
    logic                   we;
    logic [`MCU_XLEN/8-1:0] be;
    logic [`MCU_XLEN-1:0]   wdata;
  } obi_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;
    logic [`MCU_XLEN-1:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic               valid;
    logic [IRQ_IDW-1:0] id;
  } irq_t;

endpackage

`default_nettype wire

//--- rtl/mcu_top.sv
// MCU core top level
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module mcu_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  // Instruction bus, read only
  output mcu_pkg::obi_req_t            instr_obi_o,
  input  wire mcu_pkg::obi_rsp_t       instr_obi_i,
  // Data bus
  output mcu_pkg::obi_req_t            data_obi_o,
  input  wire mcu_pkg::obi_rsp_t       data_obi_i,
  // Interrupt sources and acknowledge
  input  wire logic [`MCU_NIRQ-1:0]    irq_ext_i,
  input  wire logic [`MCU_NIRQ-1:0]    irq_vp_i,
  output logic                         irq_ack_o,
  output logic [mcu_pkg::IRQ_IDW-1:0]  irq_id_o
);

  logic                          pkt_valid;
  mcu_pkg::fetch_pkt_t           pkt;
  logic                          pkt_ready;
  logic                          mem_valid;
  mcu_pkg::mem_req_t             mem_req;
  logic                          mem_ready;
  logic                          wb_valid;
  logic [mcu_pkg::REG_AW-1:0]    wb_rd;
  logic [`MCU_XLEN-1:0]          wb_data;
  mcu_pkg::irq_t                 irq;
  logic                          irq_take;
  logic [`MCU_XLEN-1:0]          redirect_addr;

  mcu_fetch u_fetch (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instr_obi_o     (instr_obi_o),
    .instr_obi_i     (instr_obi_i),
    .pkt_valid_o     (pkt_valid),
    .pkt_o           (pkt),
    .pkt_ready_i     (pkt_ready),
    .redirect_i      (irq_take),
    .redirect_addr_i (redirect_addr)
  );

  mcu_decode_exec u_decode_exec (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .pkt_valid_i     (pkt_valid),
    .pkt_i           (pkt),
    .pkt_ready_o     (pkt_ready),
    .mem_valid_o     (mem_valid),
    .mem_o           (mem_req),
    .mem_ready_i     (mem_ready),
    .wb_valid_i      (wb_valid),
    .wb_rd_i         (wb_rd),
    .wb_data_i       (wb_data),
    .irq_i           (irq),
    .irq_take_o      (irq_take),
    .redirect_addr_o (redirect_addr)
  );

  mcu_lsu u_lsu (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid),
    .mem_i       (mem_req),
    .mem_ready_o (mem_ready),
    .data_obi_o  (data_obi_o),
    .data_obi_i  (data_obi_i),
    .wb_valid_o  (wb_valid),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  mcu_irq_ctrl u_irq_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .irq_ext_i  (irq_ext_i),
    .irq_vp_i   (irq_vp_i),
    .irq_take_i (irq_take),
    .irq_o      (irq),
    .irq_ack_o  (irq_ack_o),
    .irq_id_o   (irq_id_o)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the MCU testbench with Verilator, run it and grade sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module mcu_tb -f mcu_top.f -o mcu_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/mcu_sim > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log && { echo "Simulation passed"; exit 0; }
echo "Simulation ended without a verdict, see sim.log"
exit 1

//--- verif/mcu_tb.sv
// MCU subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module mcu_tb;

  typedef struct packed {
    logic [31:0] iaddr;
    logic [31:0] instr;
    logic        st;
    logic [31:0] st_addr;
    logic [31:0] st_data;
  } row_t;

  localparam int                   MAX_ROWS = 32;
  localparam int                   DRAIN    = 20;
  localparam logic [31:0]          A_VAL    = 32'h1234_5678;
  localparam int                   B_IMM    = -933;
  localparam logic [15:0]          C_HI     = 16'hbeef;
  localparam logic [31:0]          H_VAL    = 32'h0000_002a;
  localparam logic [`MCU_NIRQ-1:0] IRQ_EXT  = 8'h28;
  localparam logic [`MCU_NIRQ-1:0] IRQ_VP   = 8'h90;

  logic                         clk_i;
  logic                         rst_n_i;
  mcu_pkg::obi_req_t            instr_obi_o;
  mcu_pkg::obi_rsp_t            instr_obi_i;
  mcu_pkg::obi_req_t            data_obi_o;
  mcu_pkg::obi_rsp_t            data_obi_i;
  logic [`MCU_NIRQ-1:0]         irq_ext_i;
  logic [`MCU_NIRQ-1:0]         irq_vp_i;
  logic                         irq_ack_o;
  logic [mcu_pkg::IRQ_IDW-1:0]  irq_id_o;

  // Memories and program table
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  row_t        rows [MAX_ROWS];
  string       names [MAX_ROWS];
  int          n_rows;
  logic [31:0] next_iaddr;
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  string       exp_name_q [$];

  // Bus model state with index 0 for the instruction bus
  logic              pend [2];
  logic [7:0]        pend_idx [2];
  logic              held [2];
  mcu_pkg::obi_req_t held_req [2];
  int                wait_cnt [2];

  int          seed;
  int          cyc;
  int          limit;
  int          rst_cnt;
  int          ack_cnt;
  int          finish_at;
  int          exp_id;
  logic        irq_raised;
  logic        vec_wait;
  logic        vec_seen;
  logic        old_valid;
  logic [31:0] old_addr;
  logic [31:0] vec_addr;

  mcu_top u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_obi_o (instr_obi_o),
    .instr_obi_i (instr_obi_i),
    .data_obi_o  (data_obi_o),
    .data_obi_i  (data_obi_i),
    .irq_ext_i   (irq_ext_i),
    .irq_vp_i    (irq_vp_i),
    .irq_ack_o   (irq_ack_o),
    .irq_id_o    (irq_id_o)
  );

  always #5 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Encoding and reporting helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] enc_r(input mcu_pkg::opcode_e op, input int rd,
                                        input int rs1, input int rs2);
    mcu_pkg::instr_u w;
    w               = '0;
    w.r_form.opcode = op;
    w.r_form.rd     = 4'(rd);
    w.r_form.rs1    = 4'(rs1);
    w.r_form.rs2    = 4'(rs2);
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input mcu_pkg::opcode_e op, input int rd,
                                        input int rs1, input logic [19:0] imm);
    mcu_pkg::instr_u w;
    w.i_form.opcode = op;
    w.i_form.rd     = 4'(rd);
    w.i_form.rs1    = 4'(rs1);
    w.i_form.imm    = imm;
    return w;
  endfunction

  function automatic int lowest_line(input logic [`MCU_NIRQ-1:0] v);
    int id;
    id = -1;
    for (int i = 0; i < `MCU_NIRQ; i++) begin
      if (id < 0 && v[i]) begin
        id = i;
      end
    end
    return id;
  endfunction

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic add_row(input string name, input logic [31:0] instr, input logic st,
                         input logic [31:0] st_addr, input logic [31:0] st_data);
    rows[n_rows].iaddr   = next_iaddr;
    rows[n_rows].instr   = instr;
    rows[n_rows].st      = st;
    rows[n_rows].st_addr = st_addr;
    rows[n_rows].st_data = st_data;
    names[n_rows]        = name;
    n_rows               = n_rows + 1;
    next_iaddr           = next_iaddr + 32'd4;
  endtask

  // ----------------------------------------------------------------------
  // Program table
  // ----------------------------------------------------------------------

  task automatic build_program();
    logic [31:0] b_val;
    logic [31:0] c_val;
    b_val = 32'(B_IMM);
    c_val = {C_HI, 16'h0000};
    add_row("", enc_i(mcu_pkg::OP_LUI, 1, 0, {4'h0, A_VAL[31:16]}), 0, 0, 0);
    add_row("", enc_i(mcu_pkg::OP_ADDI, 1, 1, {4'h0, A_VAL[15:0]}), 0, 0, 0);
    add_row("", enc_i(mcu_pkg::OP_ADDI, 2, 0, 20'(B_IMM)), 0, 0, 0);
    add_row("", enc_i(mcu_pkg::OP_ADDI, 12, 0, 20'(H_VAL)), 0, 0, 0);
    add_row("", enc_i(mcu_pkg::OP_ADDI, 13, 0, 20'h00070), 0, 0, 0);
    add_row("lui addi build", enc_i(mcu_pkg::OP_SW, 1, 0, 20'h00040), 1, 32'h40, A_VAL);
    add_row("addi negative", enc_i(mcu_pkg::OP_SW, 2, 0, 20'h00044), 1, 32'h44, b_val);
    add_row("", enc_r(mcu_pkg::OP_ADD, 3, 1, 2), 0, 0, 0);
    add_row("add", enc_i(mcu_pkg::OP_SW, 3, 0, 20'h00048), 1, 32'h48, A_VAL + b_val);
    add_row("", enc_r(mcu_pkg::OP_SUB, 4, 1, 2), 0, 0, 0);
    add_row("sub", enc_i(mcu_pkg::OP_SW, 4, 0, 20'h0004c), 1, 32'h4c, A_VAL - b_val);
    add_row("", enc_r(mcu_pkg::OP_AND, 5, 1, 2), 0, 0, 0);
    add_row("and", enc_i(mcu_pkg::OP_SW, 5, 0, 20'h00050), 1, 32'h50, A_VAL & b_val);
    add_row("", enc_r(mcu_pkg::OP_OR, 6, 1, 2), 0, 0, 0);
    add_row("or", enc_i(mcu_pkg::OP_SW, 6, 0, 20'h00054), 1, 32'h54, A_VAL | b_val);
    add_row("", enc_r(mcu_pkg::OP_XOR, 7, 1, 2), 0, 0, 0);
    add_row("xor", enc_i(mcu_pkg::OP_SW, 7, 0, 20'h00058), 1, 32'h58, A_VAL ^ b_val);
    add_row("", enc_r(mcu_pkg::OP_ADD, 0, 1, 2), 0, 0, 0);
    add_row("r0 zero", enc_i(mcu_pkg::OP_SW, 0, 0, 20'h0005c), 1, 32'h5c, 32'h0);
    add_row("", enc_i(mcu_pkg::OP_LUI, 8, 0, {4'h0, C_HI}), 0, 0, 0);
    add_row("lui upper", enc_i(mcu_pkg::OP_SW, 8, 0, 20'h00060), 1, 32'h60, c_val);
    add_row("", enc_i(mcu_pkg::OP_ADDI, 9, 8, 20'hf_ffff), 0, 0, 0);
    add_row("addi borrow", enc_i(mcu_pkg::OP_SW, 9, 0, 20'h00064), 1, 32'h64, c_val - 1);
    // Store right behind the load exercises the interlock
    add_row("", enc_i(mcu_pkg::OP_LW, 10, 0, 20'h00048), 0, 0, 0);
    add_row("load store", enc_i(mcu_pkg::OP_SW, 10, 0, 20'h00068), 1, 32'h68, A_VAL + b_val);
    // Handler at the vector of the expected line
    next_iaddr = vec_addr;
    add_row("irq handler", enc_i(mcu_pkg::OP_SW, 12, 13, 20'h00010), 1, 32'h80, H_VAL);
  endtask

  // ----------------------------------------------------------------------
  // Bus models and monitors
  // ----------------------------------------------------------------------

  task automatic take_store(input mcu_pkg::obi_req_t rq);
    if (exp_addr_q.size() == 0) begin
      $display("Unexpected store to %08h with data %08h", rq.addr, rq.wdata);
      stop_run();
    end else begin
      check({exp_name_q[0], " addr"}, exp_addr_q[0], rq.addr);
      check({exp_name_q[0], " data"}, exp_data_q[0], rq.wdata);
      exp_addr_q.delete(0);
      exp_data_q.delete(0);
      exp_name_q.delete(0);
      dmem[rq.addr[9:2]] = rq.wdata;
    end
  endtask

  // Grant after 0 to 3 cycles and rvalid in the cycle after the grant
  task automatic serve_bus(input int b, input mcu_pkg::obi_req_t rq,
                           output mcu_pkg::obi_rsp_t rsp);
    string bus;
    bus = (b == 0) ? "instr" : "data";
    rsp = '0;
    if (pend[b]) begin
      rsp.rvalid = 1'b1;
      rsp.rdata  = (b == 0) ? imem[pend_idx[b]] : dmem[pend_idx[b]];
      pend[b]    = 1'b0;
    end else if (rq.req) begin
      if (held[b]) begin
        check({bus, " addr stable"}, held_req[b].addr, rq.addr);
        check({bus, " wdata stable"}, held_req[b].wdata, rq.wdata);
        check({bus, " we stable"}, 32'(held_req[b].we), 32'(rq.we));
      end else begin
        check({bus, " be"}, 32'hf, 32'(rq.be));
        if (b == 0) begin
          check("instr we", 32'd0, 32'(rq.we));
        end
        held[b]     = 1'b1;
        held_req[b] = rq;
        wait_cnt[b] = $random(seed) & 3;
      end
      if (wait_cnt[b] == 0) begin
        rsp.gnt     = 1'b1;
        held[b]     = 1'b0;
        pend[b]     = 1'b1;
        pend_idx[b] = rq.addr[9:2];
        if (b == 1 && rq.we) begin
          take_store(rq);
        end
      end else begin
        wait_cnt[b] = wait_cnt[b] - 1;
      end
    end else if (held[b]) begin
      $display("The %s request was withdrawn before its grant", bus);
      stop_run();
    end
  endtask

  task automatic watch_irq(input mcu_pkg::obi_req_t ireq);
    if (irq_ack_o) begin
      ack_cnt = ack_cnt + 1;
      check("irq raised before ack", 32'd1, 32'(irq_raised));
      check("irq ack count", 32'd1, ack_cnt);
      check("irq id", exp_id, 32'(irq_id_o));
      irq_ext_i = '0;
      irq_vp_i  = '0;
      vec_wait  = 1'b1;
      // A request still held from the old stream may finish first
      old_valid = ireq.req && (ireq.addr != vec_addr);
      old_addr  = ireq.addr;
    end
    if (vec_wait && ireq.req && !(old_valid && ireq.addr == old_addr)) begin
      check("irq vector fetch addr", vec_addr, ireq.addr);
      vec_wait = 1'b0;
      vec_seen = 1'b1;
    end
    // Raise both sources once only the handler store is left
    if (!irq_raised && exp_addr_q.size() == 1) begin
      irq_ext_i  = IRQ_EXT;
      irq_vp_i   = IRQ_VP;
      irq_raised = 1'b1;
    end
  endtask

  // ----------------------------------------------------------------------
  // Falling edge sampling and driving
  // ----------------------------------------------------------------------

  always @(negedge clk_i) begin : tick
    mcu_pkg::obi_req_t ireq;
    mcu_pkg::obi_req_t dreq;
    mcu_pkg::obi_rsp_t irsp;
    mcu_pkg::obi_rsp_t drsp;
    cyc  = cyc + 1;
    ireq = instr_obi_o;
    dreq = data_obi_o;
    if (cyc > limit) begin
      $display("Timeout after %0d cycles, %0d stores still expected", cyc, exp_addr_q.size());
      stop_run();
    end else if (!rst_n_i) begin
      check("reset instr req", 32'd0, 32'(ireq.req));
      check("reset data req", 32'd0, 32'(dreq.req));
      check("reset irq ack", 32'd0, 32'(irq_ack_o));
      if (cyc >= 5) begin
        rst_n_i = 1'b1;
      end
    end else begin
      if (rst_cnt == 0) begin
        check("data req after reset", 32'd0, 32'(dreq.req));
        check("irq ack after reset", 32'd0, 32'(irq_ack_o));
        check("first fetch req", 32'd1, 32'(ireq.req));
        check("first fetch addr", `MCU_BOOT_ADDR, ireq.addr);
      end
      rst_cnt = rst_cnt + 1;
      serve_bus(0, ireq, irsp);
      serve_bus(1, dreq, drsp);
      watch_irq(ireq);
      instr_obi_i = irsp;
      data_obi_i  = drsp;
      if (finish_at == 0 && exp_addr_q.size() == 0 && vec_seen) begin
        finish_at = cyc + DRAIN;
      end
      if (finish_at != 0 && cyc >= finish_at) begin
        if (ack_cnt == 1 && exp_addr_q.size() == 0) begin
          $display("TEST OK");
          $finish;
        end else begin
          $display("Run ended with %0d acknowledges and %0d stores missing",
                   ack_cnt, exp_addr_q.size());
          stop_run();
        end
      end
    end
  end

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    instr_obi_i = '0;
    data_obi_i  = '0;
    irq_ext_i   = '0;
    irq_vp_i    = '0;
    seed        = 32'h0688_f06d;
    cyc         = 0;
    rst_cnt     = 0;
    ack_cnt     = 0;
    finish_at   = 0;
    irq_raised  = 1'b0;
    vec_wait    = 1'b0;
    vec_seen    = 1'b0;
    old_valid   = 1'b0;
    old_addr    = '0;
    for (int b = 0; b < 2; b++) begin
      pend[b]     = 1'b0;
      pend_idx[b] = '0;
      held[b]     = 1'b0;
      held_req[b] = '0;
      wait_cnt[b] = 0;
    end
    exp_id     = lowest_line(IRQ_EXT | IRQ_VP);
    vec_addr   = `MCU_IRQ_VEC_BASE + 32'(4 * exp_id);
    n_rows     = 0;
    next_iaddr = `MCU_BOOT_ADDR;
    build_program();
    // NOP fill carries the word address in its unused bits
    for (int i = 0; i < 256; i++) begin
      imem[i] = {4'h0, 28'(i * 4)};
      dmem[i] = 32'h5a5a_0000 ^ 32'(i * 4);
    end
    for (int r = 0; r < n_rows; r++) begin
      imem[rows[r].iaddr[9:2]] = rows[r].instr;
      if (rows[r].st) begin
        exp_addr_q.push_back(rows[r].st_addr);
        exp_data_q.push_back(rows[r].st_data);
        exp_name_q.push_back(names[r]);
      end
    end
    limit = 40 * n_rows + 200;
  end

endmodule

`default_nettype wire
